//--- Makefile
# Verilator build and run of the HWPE subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_hwpe_subsystem
RTL_TOP   ?= hwpe_subsystem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= *** TEST PASSED ***

SIM      := $(OBJ_DIR)/V$(TOP)
RTL_SRCS := $(filter-out tb_%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

//--- hwpe_cfg_decode.sv
/*
 * Config port decode: grant, per-engine enables and request routing
 * Grant follows hwpe_en_i only, so a disabled subsystem back-pressures
 * Addresses outside the register window map to an undefined index
 */

`default_nettype none

module hwpe_cfg_decode (
  input  logic                                         hwpe_en_i,
  input  logic [hwpe_pkg::SEL_W-1:0]                   hwpe_sel_i,
  input  hwpe_pkg::cfg_req_t                           cfg_req_i,
  output logic                                         gnt_o,
  output logic [hwpe_pkg::N_HWPES-1:0]                 en_o,
  output hwpe_pkg::eng_acc_t [hwpe_pkg::N_HWPES-1:0]   acc_o
);

  import hwpe_pkg::*;

  logic                 in_window;
  logic [REG_IDX_W-1:0] reg_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Grant and address decode
  ////////////////////////////////////////////////////////////////////////////

  // Combinational grant, no wait states when enabled
  assign gnt_o = hwpe_en_i;

  // Word-aligned and inside the small per-engine window
  assign in_window = (cfg_req_i.add[AW-1:REG_IDX_W+2] == '0) &&
                     (cfg_req_i.add[1:0] == 2'b00);

  // All ones is never a defined register
  // so out-of-window accesses read zero and write nothing
  assign reg_idx = in_window ? cfg_req_i.add[REG_IDX_W+1:2] : '1;

  ////////////////////////////////////////////////////////////////////////////
  // Per-engine routing
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_HWPES; i++) begin : gen_route

    // Enable stands in for the gated clock of engine i
    assign en_o[i] = hwpe_en_i && (hwpe_sel_i == SEL_W'(i));

    always_comb begin
      // Only the selected and enabled engine sees a valid request
      acc_o[i].req     = cfg_req_i.req && en_o[i];
      // Payload is broadcast
      acc_o[i].wen     = cfg_req_i.wen;
      acc_o[i].reg_idx = reg_idx;
      acc_o[i].wdata   = cfg_req_i.wdata;
      acc_o[i].id      = cfg_req_i.id;
    end

  end

endmodule

`default_nettype wire

//--- hwpe_engine.sv
/*
 * Reduction engine: register file, job FSM and sum/xor/max datapath
 * State only moves while en_i is high, modelling a gated clock
 * Up to two memory reads in flight, memory answers one cycle after grant
 */

`default_nettype none

module hwpe_engine (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               en_i,
  input  hwpe_pkg::eng_acc_t acc_i,
  input  hwpe_pkg::mem_rsp_t mem_rsp_i,
  output hwpe_pkg::cfg_rsp_t rsp_o,
  output hwpe_pkg::mem_req_t mem_req_o,
  output logic               busy_o,
  output logic               evt_o
);

  import hwpe_pkg::*;

  state_e        state_q;
  state_e        state_d;
  opcode_e       op_q;
  logic [AW-1:0] src_q;
  logic [AW-1:0] addr_q;
  logic [DW-1:0] len_q;
  logic [DW-1:0] iss_cnt_q;
  logic [DW-1:0] rcv_cnt_q;
  logic [DW-1:0] acc_q;
  logic [DW-1:0] acc_next;
  logic [DW-1:0] result_q;
  logic [DW-1:0] rdata;
  logic          cfg_wr;
  logic          start;
  logic          issue;
  logic          take;
  logic          last;

  ////////////////////////////////////////////////////////////////////////////
  // Control strobes
  ////////////////////////////////////////////////////////////////////////////

  assign busy_o = (state_q == FETCH) || (state_q == DRAIN);
  assign evt_o  = (state_q == DONE);

  // Register writes only land while idle
  assign cfg_wr = acc_i.req && !acc_i.wen && !busy_o;
  assign start  = cfg_wr && (acc_i.reg_idx == REG_TRIGGER[REG_IDX_W+1:2]);
  assign issue  = (state_q == FETCH) && mem_rsp_i.gnt;
  assign take   = busy_o && mem_rsp_i.r_valid;
  assign last   = (rcv_cnt_q == len_q - DW'(1));

  // Hold address and request until granted
  assign mem_req_o.req  = (state_q == FETCH);
  assign mem_req_o.addr = addr_q;

  // Reduction step on the returned word
  always_comb begin
    case (op_q)
      OP_SUM:  acc_next = acc_q + mem_rsp_i.r_data;
      OP_XOR:  acc_next = acc_q ^ mem_rsp_i.r_data;
      OP_MAX:  acc_next = (mem_rsp_i.r_data > acc_q) ? mem_rsp_i.r_data : acc_q;
      default: acc_next = acc_q;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        // DONE lasts one cycle unless a new job starts right away
        if (start) state_d = (len_q == '0) ? DONE : FETCH;
        else       state_d = IDLE;
      end
      FETCH: if (issue && (iss_cnt_q == len_q - DW'(1))) state_d = DRAIN;
      DRAIN: if (take && last) state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      op_q      <= OP_SUM;
      src_q     <= '0;
      len_q     <= '0;
      addr_q    <= '0;
      iss_cnt_q <= '0;
      rcv_cnt_q <= '0;
      acc_q     <= '0;
      result_q  <= '0;
    end else if (en_i) begin
      state_q <= state_d;
      if (cfg_wr) begin
        case (acc_i.reg_idx)
          REG_SRC[REG_IDX_W+1:2]: src_q <= acc_i.wdata;
          REG_LEN[REG_IDX_W+1:2]: len_q <= acc_i.wdata;
          REG_OP[REG_IDX_W+1:2]:  op_q  <= opcode_e'(acc_i.wdata[1:0]);
          default: ;
        endcase
      end
      // Fresh job, identity is zero for every opcode
      if (start) begin
        addr_q    <= src_q;
        iss_cnt_q <= '0;
        rcv_cnt_q <= '0;
        acc_q     <= '0;
        if (len_q == '0) result_q <= '0;
      end
      if (issue) begin
        addr_q    <= addr_q + AW'(4);
        iss_cnt_q <= iss_cnt_q + DW'(1);
      end
      if (take) begin
        rcv_cnt_q <= rcv_cnt_q + DW'(1);
        acc_q     <= acc_next;
        if (last) result_q <= acc_next;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Config response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (acc_i.reg_idx)
      REG_SRC[REG_IDX_W+1:2]:    rdata = src_q;
      REG_LEN[REG_IDX_W+1:2]:    rdata = len_q;
      REG_OP[REG_IDX_W+1:2]:     rdata = DW'(op_q);
      REG_RESULT[REG_IDX_W+1:2]: rdata = result_q;
      REG_STATUS[REG_IDX_W+1:2]: rdata = DW'(busy_o);
      default:                   rdata = '0;
    endcase
  end

  // Response pulse sits outside the enable so it never sticks high
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_o.r_valid <= 1'b0;
      rsp_o.r_data  <= '0;
      rsp_o.r_id    <= '0;
    end else begin
      rsp_o.r_valid <= acc_i.req;
      if (acc_i.req) begin
        rsp_o.r_data <= acc_i.wen ? rdata : '0;
        rsp_o.r_id   <= acc_i.id;
      end
    end
  end

  // Grant comes from the decode stage
  assign rsp_o.gnt = 1'b0;

endmodule

`default_nettype wire

//--- hwpe_pkg.sv
/*
 * Shared widths, register map and bus types of the two-engine HWPE subsystem
 * Engine count and select width are fixed here and must change together
 * Memory side is read-only, no byte enables
 */

`default_nettype none

package hwpe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned N_HWPES = 2;
  localparam int unsigned SEL_W   = 1;
  localparam int unsigned DW      = 32;
  localparam int unsigned AW      = 32;
  localparam int unsigned ID_W    = 8;

  // Word index inside one engine's register window
  localparam int unsigned REG_IDX_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Register map (byte offsets)
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [AW-1:0] REG_SRC     = 32'h0000_0000;
  localparam logic [AW-1:0] REG_LEN     = 32'h0000_0004;
  localparam logic [AW-1:0] REG_OP      = 32'h0000_0008;
  localparam logic [AW-1:0] REG_TRIGGER = 32'h0000_000C;
  localparam logic [AW-1:0] REG_RESULT  = 32'h0000_0010;
  localparam logic [AW-1:0] REG_STATUS  = 32'h0000_0014;

  // Reduction operations, all with identity zero
  typedef enum logic [1:0] {
    OP_SUM = 2'd0,
    OP_XOR = 2'd1,
    OP_MAX = 2'd2
  } opcode_e;

  // Job FSM
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FETCH = 2'd1,
    DRAIN = 2'd2,
    DONE  = 2'd3
  } state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bus types
  ////////////////////////////////////////////////////////////////////////////

  // Periph-style config request, wen high means read
  typedef struct packed {
    logic            req;
    logic            wen;
    logic [AW-1:0]   add;
    logic [DW-1:0]   wdata;
    logic [ID_W-1:0] id;
  } cfg_req_t;

  typedef struct packed {
    logic            gnt;
    logic            r_valid;
    logic [DW-1:0]   r_data;
    logic [ID_W-1:0] r_id;
  } cfg_rsp_t;

  // Access after decode, already routed to one engine
  typedef struct packed {
    logic                 req;
    logic                 wen;
    logic [REG_IDX_W-1:0] reg_idx;
    logic [DW-1:0]        wdata;
    logic [ID_W-1:0]      id;
  } eng_acc_t;

  typedef struct packed {
    logic          req;
    logic [AW-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic          gnt;
    logic          r_valid;
    logic [DW-1:0] r_data;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- hwpe_result_mux.sv
/*
 * Static selection of the chosen engine towards the outside
 * hwpe_sel_i must stay stable from grant to response and during a job
 */

`default_nettype none

module hwpe_result_mux (
  input  logic [hwpe_pkg::SEL_W-1:0]                 hwpe_sel_i,
  input  logic                                       gnt_i,
  input  hwpe_pkg::cfg_rsp_t [hwpe_pkg::N_HWPES-1:0] eng_rsp_i,
  input  hwpe_pkg::mem_req_t [hwpe_pkg::N_HWPES-1:0] eng_mem_req_i,
  input  hwpe_pkg::mem_rsp_t                         mem_rsp_i,
  input  logic [hwpe_pkg::N_HWPES-1:0]               eng_busy_i,
  input  logic [hwpe_pkg::N_HWPES-1:0]               eng_evt_i,
  output hwpe_pkg::cfg_rsp_t                         cfg_rsp_o,
  output hwpe_pkg::mem_req_t                         mem_req_o,
  output hwpe_pkg::mem_rsp_t [hwpe_pkg::N_HWPES-1:0] eng_mem_rsp_o,
  output logic                                       busy_o,
  output logic                                       evt_o
);

  import hwpe_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Engine to outside
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Engine 0 is the default choice
    cfg_rsp_o = eng_rsp_i[0];
    mem_req_o = eng_mem_req_i[0];
    busy_o    = eng_busy_i[0];
    evt_o     = eng_evt_i[0];
    for (int i = 1; i < N_HWPES; i++) begin
      if (hwpe_sel_i == SEL_W'(i)) begin
        cfg_rsp_o = eng_rsp_i[i];
        mem_req_o = eng_mem_req_i[i];
        busy_o    = eng_busy_i[i];
        evt_o     = eng_evt_i[i];
      end
    end
    // Engines leave gnt open, decode owns it
    cfg_rsp_o.gnt = gnt_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outside to engines
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_HWPES; i++) begin : gen_mem_rsp
    always_comb begin
      eng_mem_rsp_o[i]     = mem_rsp_i;
      // Memory grant reaches the selected engine only
      eng_mem_rsp_o[i].gnt = mem_rsp_i.gnt && (hwpe_sel_i == SEL_W'(i));
    end
  end

endmodule

`default_nettype wire

//--- hwpe_subsystem.sv
/*
 * Two reduction engines behind one config port and one memory master
 * hwpe_en_i and hwpe_sel_i pick the live engine, the other one is frozen
 * No real clock gating and no test mode, events are a single done pulse
 */

`default_nettype none

module hwpe_subsystem (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       hwpe_en_i,
  input  logic [hwpe_pkg::SEL_W-1:0] hwpe_sel_i,
  input  hwpe_pkg::cfg_req_t         cfg_req_i,
  output hwpe_pkg::cfg_rsp_t         cfg_rsp_o,
  output hwpe_pkg::mem_req_t         mem_req_o,
  input  hwpe_pkg::mem_rsp_t         mem_rsp_i,
  output logic                       busy_o,
  output logic                       evt_o
);

  import hwpe_pkg::*;

  logic                       cfg_gnt;
  logic [N_HWPES-1:0]         eng_en;
  eng_acc_t [N_HWPES-1:0]     eng_acc;
  cfg_rsp_t [N_HWPES-1:0]     eng_rsp;
  mem_req_t [N_HWPES-1:0]     eng_mem_req;
  mem_rsp_t [N_HWPES-1:0]     eng_mem_rsp;
  logic [N_HWPES-1:0]         eng_busy;
  logic [N_HWPES-1:0]         eng_evt;

  ////////////////////////////////////////////////////////////////////////////
  // Config decode
  ////////////////////////////////////////////////////////////////////////////

  hwpe_cfg_decode u_cfg_decode (
    .hwpe_en_i  ( hwpe_en_i  ),
    .hwpe_sel_i ( hwpe_sel_i ),
    .cfg_req_i  ( cfg_req_i  ),
    .gnt_o      ( cfg_gnt    ),
    .en_o       ( eng_en     ),
    .acc_o      ( eng_acc    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Engines
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_HWPES; i++) begin : u_engine
    hwpe_engine u_engine (
      .clk       ( clk            ),
      .arst_n_i  ( arst_n_i       ),
      .en_i      ( eng_en[i]      ),
      .acc_i     ( eng_acc[i]     ),
      .mem_rsp_i ( eng_mem_rsp[i] ),
      .rsp_o     ( eng_rsp[i]     ),
      .mem_req_o ( eng_mem_req[i] ),
      .busy_o    ( eng_busy[i]    ),
      .evt_o     ( eng_evt[i]     )
    );
  end

  // Responses, memory master and status of the selected engine
  hwpe_result_mux u_result_mux (
    .hwpe_sel_i    ( hwpe_sel_i  ),
    .gnt_i         ( cfg_gnt     ),
    .eng_rsp_i     ( eng_rsp     ),
    .eng_mem_req_i ( eng_mem_req ),
    .mem_rsp_i     ( mem_rsp_i   ),
    .eng_busy_i    ( eng_busy    ),
    .eng_evt_i     ( eng_evt     ),
    .cfg_rsp_o     ( cfg_rsp_o   ),
    .mem_req_o     ( mem_req_o   ),
    .eng_mem_rsp_o ( eng_mem_rsp ),
    .busy_o        ( busy_o      ),
    .evt_o         ( evt_o       )
  );

endmodule

`default_nettype wire

//--- sources.f
hwpe_pkg.sv
hwpe_cfg_decode.sv
hwpe_engine.sv
hwpe_result_mux.sv
hwpe_subsystem.sv
tb_hwpe_subsystem.sv

//--- tb_hwpe_subsystem.sv
/*
 * Testbench for the two-engine HWPE subsystem
 * Memory model grants on LFSR bits and answers one cycle after each grant
 * Inputs change 2 units after the rising edge and outputs are sampled on the falling edge
 */

`default_nettype none

module tb_hwpe_subsystem;

  import hwpe_pkg::*;

  localparam int          PERIOD      = 20;
  localparam int          IN_DLY      = 2;
  localparam logic [31:0] LFSR_SEED   = 32'h2d054754;
  // Longest zero run of the LFSR is 31 bits, so each word is granted within this bound
  localparam int          STALL_BOUND = 40;
  localparam int          N_JOBS      = 14;
  localparam int          MAX_LEN     = 16;
  localparam int          JOB_LIMIT   = (MAX_LEN + 4) * STALL_BOUND;
  localparam int          GNT_LIMIT   = 16;
  localparam int          WATCHDOG_T  = (N_JOBS * MAX_LEN * STALL_BOUND + 800) * PERIOD;

  logic             clk;
  logic             arst_n;
  logic             hwpe_en;
  logic [SEL_W-1:0] hwpe_sel;
  cfg_req_t         cfg_req;
  cfg_rsp_t         cfg_rsp;
  mem_req_t         mem_req;
  mem_rsp_t         mem_rsp;
  logic             busy;
  logic             evt;

  logic [31:0] mem [64];
  logic [31:0] lfsr_q;
  logic        mem_granted;
  logic [5:0]  mem_gidx;
  logic [7:0]  next_id;
  int          last_waits;
  int          evt_cnt;
  logic        job_on;

  hwpe_subsystem u_dut (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n   ),
    .hwpe_en_i  ( hwpe_en  ),
    .hwpe_sel_i ( hwpe_sel ),
    .cfg_req_i  ( cfg_req  ),
    .cfg_rsp_o  ( cfg_rsp  ),
    .mem_req_o  ( mem_req  ),
    .mem_rsp_i  ( mem_rsp  ),
    .busy_o     ( busy     ),
    .evt_o      ( evt      )
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Expected reduction over LEN words from byte address src
  function automatic logic [31:0] ref_reduce(input logic [31:0] src, input logic [31:0] len,
                                             input opcode_e op);
    logic [31:0] acc;
    logic [31:0] w;
    logic [5:0]  idx;
    acc = '0;
    for (int k = 0; 32'(k) < len; k++) begin
      idx = 6'((src >> 2) + 32'(k));
      w   = mem[idx];
      case (op)
        OP_SUM:  acc = acc + w;
        OP_XOR:  acc = acc ^ w;
        default: acc = (w > acc) ? w : acc;
      endcase
    end
    return acc;
  endfunction

  task automatic stop_fail();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_fail();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  // Grant is seen before the edge and answered after it
  initial begin
    mem_granted = 1'b0;
    mem_gidx    = '0;
    forever begin
      @(negedge clk);
      mem_granted = mem_req.req && mem_rsp.gnt;
      mem_gidx    = mem_req.addr[7:2];
    end
  end

  initial begin : mem_drive
    logic        in_rst;
    logic [31:0] gnt_bits;
    mem_rsp = '0;
    forever begin
      @(posedge clk);
      in_rst = !arst_n;
      #IN_DLY;
      if (in_rst) begin
        mem_rsp = '0;
      end else begin
        mem_rsp.r_valid = mem_granted;
        mem_rsp.r_data  = mem_granted ? mem[mem_gidx] : '0;
        // Grant when the next LFSR bit is one
        gnt_bits        = rand_bits(1);
        mem_rsp.gnt     = gnt_bits[0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Done and busy monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    evt_cnt = 0;
    job_on  = 1'b0;
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if (evt) begin
          check("evt_o", 32'(job_on), 32'(evt));
          // busy_o is already low in the done cycle
          check("busy_o", 32'd0, 32'(busy));
          evt_cnt++;
          job_on = 1'b0;
        end else begin
          check("busy_o", 32'(job_on), 32'(busy));
        end
        // A granted TRIGGER write makes busy_o rise from the next edge on
        if (cfg_req.req && cfg_rsp.gnt && !cfg_req.wen && cfg_req.add == REG_TRIGGER) begin
          job_on = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Config bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic cfg_access(input logic wen, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic [7:0] id;
    id      = next_id;
    next_id = next_id + 8'd1;
    @(posedge clk);
    #IN_DLY;
    cfg_req.req   = 1'b1;
    cfg_req.wen   = wen;
    cfg_req.add   = addr;
    cfg_req.wdata = wdata;
    cfg_req.id    = id;
    last_waits    = 0;
    @(negedge clk);
    // No response may appear while the request waits
    while (!cfg_rsp.gnt) begin
      check("cfg_rsp_o.r_valid", 32'd0, 32'(cfg_rsp.r_valid));
      last_waits++;
      if (last_waits > GNT_LIMIT) begin
        $display("Config request at %h was never granted", addr);
        stop_fail();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #IN_DLY;
    cfg_req.req = 1'b0;
    @(negedge clk);
    check("cfg_rsp_o.r_valid", 32'd1, 32'(cfg_rsp.r_valid));
    check("cfg_rsp_o.r_id", 32'(id), 32'(cfg_rsp.r_id));
    if (!wen) check("cfg_rsp_o.r_data", 32'd0, cfg_rsp.r_data);
    rdata = cfg_rsp.r_data;
  endtask

  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    cfg_access(1'b0, addr, data, ignored);
  endtask

  task automatic cfg_read(input logic [31:0] addr, output logic [31:0] data);
    cfg_access(1'b1, addr, 32'd0, data);
  endtask

  task automatic select_engine(input logic [SEL_W-1:0] sel);
    @(posedge clk);
    #IN_DLY;
    hwpe_sel = sel;
  endtask

  task automatic start_job(input logic [31:0] src, input logic [31:0] len, input opcode_e op,
                           output int start_cnt);
    cfg_write(REG_SRC, src);
    cfg_write(REG_LEN, len);
    cfg_write(REG_OP, 32'(op));
    start_cnt = evt_cnt;
    cfg_write(REG_TRIGGER, 32'd1);
  endtask

  task automatic finish_job(input logic [31:0] src, input logic [31:0] len, input opcode_e op,
                            input int start_cnt);
    logic [31:0] res;
    int          n;
    n = 0;
    while (evt_cnt == start_cnt) begin
      @(posedge clk);
      n++;
      if (n > JOB_LIMIT) begin
        $display("Job never raised evt_o within %0d cycles", JOB_LIMIT);
        stop_fail();
      end
    end
    cfg_read(REG_RESULT, res);
    check("RESULT", ref_reduce(src, len, op), res);
    // A second pulse would already be counted by now
    check("evt_o pulses", 32'(start_cnt + 1), 32'(evt_cnt));
  endtask

  task automatic run_job(input logic [31:0] src, input logic [31:0] len, input opcode_e op);
    int cnt;
    start_job(src, len, op, cnt);
    finish_job(src, len, op, cnt);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] src;
    logic [31:0] len;
    int          cnt;
    arst_n   = 1'b0;
    hwpe_en  = 1'b0;
    hwpe_sel = '0;
    cfg_req  = '0;
    next_id  = 8'h01;
    lfsr_q   = LFSR_SEED;
    for (int i = 0; i < 64; i++) mem[i] = rand_bits(32);
    repeat (2) @(posedge clk);
    #IN_DLY;
    arst_n  = 1'b1;
    hwpe_en = 1'b1;

    // Quiet outputs and cleared registers out of reset
    @(negedge clk);
    check("busy_o", 32'd0, 32'(busy));
    check("evt_o", 32'd0, 32'(evt));
    check("mem_req_o.req", 32'd0, 32'(mem_req.req));
    check("cfg_rsp_o.r_valid", 32'd0, 32'(cfg_rsp.r_valid));
    cfg_read(REG_RESULT, rd);
    check("RESULT", 32'd0, rd);

    // Register read back and zero from undefined offsets
    cfg_write(REG_SRC, 32'hdead_beec);
    cfg_read(REG_SRC, rd);
    check("SRC", 32'hdead_beec, rd);
    cfg_write(REG_LEN, 32'h0000_0123);
    cfg_read(REG_LEN, rd);
    check("LEN", 32'h0000_0123, rd);
    cfg_write(REG_OP, 32'(OP_MAX));
    cfg_read(REG_OP, rd);
    check("OP", 32'(OP_MAX), rd);
    cfg_read(32'h0000_0018, rd);
    check("undefined 0x18", 32'd0, rd);
    cfg_read(32'h0000_0100, rd);
    check("undefined 0x100", 32'd0, rd);

    // Random reductions on engine 0
    for (int op = 0; op < 3; op++) begin
      for (int j = 0; j < 3; j++) begin
        src = rand_bits(5) << 2;
        len = rand_bits(4) + 32'd1;
        run_job(src, len, opcode_e'(2'(op)));
      end
    end

    // Zero length gives one pulse and the identity result
    run_job(32'h0000_0008, 32'd0, OP_MAX);

    // Engine 1 job must not touch engine 0
    cfg_write(REG_SRC, 32'h0000_0040);
    cfg_write(REG_LEN, 32'd5);
    cfg_write(REG_OP, 32'(OP_XOR));
    select_engine(1'b1);
    run_job(32'h0000_0020, 32'd9, OP_SUM);
    select_engine(1'b0);
    cfg_read(REG_SRC, rd);
    check("engine 0 SRC", 32'h0000_0040, rd);
    cfg_read(REG_LEN, rd);
    check("engine 0 LEN", 32'd5, rd);
    cfg_read(REG_OP, rd);
    check("engine 0 OP", 32'(OP_XOR), rd);
    cnt = evt_cnt;
    cfg_write(REG_TRIGGER, 32'd1);
    finish_job(32'h0000_0040, 32'd5, OP_XOR, cnt);

    // Request waits three cycles for the enable under back-pressure
    @(posedge clk);
    #IN_DLY;
    hwpe_en = 1'b0;
    fork
      cfg_read(REG_SRC, rd);
      begin
        repeat (4) @(posedge clk);
        #IN_DLY;
        hwpe_en = 1'b1;
      end
    join
    check("cfg stall cycles", 32'd3, 32'(last_waits));
    check("SRC after stall", 32'h0000_0040, rd);

    // Writes while busy are dropped
    start_job(32'h0000_0010, 32'd16, OP_SUM, cnt);
    cfg_read(REG_STATUS, rd);
    check("STATUS", 32'd1, rd);
    cfg_write(REG_SRC, 32'h0000_0080);
    cfg_write(REG_LEN, 32'd3);
    cfg_write(REG_OP, 32'(OP_MAX));
    cfg_write(REG_TRIGGER, 32'd1);
    finish_job(32'h0000_0010, 32'd16, OP_SUM, cnt);
    cfg_read(REG_SRC, rd);
    check("SRC kept", 32'h0000_0010, rd);
    cfg_read(REG_LEN, rd);
    check("LEN kept", 32'd16, rd);
    cfg_read(REG_OP, rd);
    check("OP kept", 32'(OP_SUM), rd);

    $display("*** TEST PASSED ***");
    $finish;
  end

  // Bound from the longest possible jobs plus config traffic
  initial begin
    #(WATCHDOG_T);
    $display("Run timed out after %0t, a job or handshake never finished", $time);
    stop_fail();
  end

endmodule

`default_nettype wire
